/* verilog/realign_cfg.svh */
//--------------------------------------------------------------------------
// widths and slot count shared by the fetch re-aligner packages and RTL
//--------------------------------------------------------------------------
`ifndef REALIGN_CFG_SVH
`define REALIGN_CFG_SVH

// virtual address width of the fetch path
`define REALIGN_VLEN 32

// width of one aligned block delivered by the instruction cache
`define REALIGN_FETCH_WIDTH 32

// smallest instruction parcel, one compressed instruction
`define REALIGN_HALF_WIDTH 16

// instruction slots produced per fetch block
`define REALIGN_INSTR_PER_FETCH 2

`endif

/* verilog/fetch_pkg.sv */
//--------------------------------------------------------------------------
// fetch block types as delivered by the instruction cache
//--------------------------------------------------------------------------
`include "realign_cfg.svh"

package fetch_pkg;

    // number of 16-bit parcels in one fetch block
    localparam int unsigned HALVES_PER_FETCH = `REALIGN_FETCH_WIDTH / `REALIGN_HALF_WIDTH;

    // instruction address
    typedef logic [`REALIGN_VLEN-1:0] addr_t;

    //----------------------------------------------------------------------
    // fetch word views
    //----------------------------------------------------------------------
    // the same word is seen as one full instruction or as parcels,
    // the parcel at index 0 being the lower half
    typedef union packed {
        logic [`REALIGN_FETCH_WIDTH-1:0]                        full;
        logic [HALVES_PER_FETCH-1:0][`REALIGN_HALF_WIDTH-1:0]   half;
    } fetch_word_u;

    // one fetch strobe from the cache, consumed in the cycle it is valid
    typedef struct packed {
        logic        valid;
        addr_t       addr;
        fetch_word_u word;
    } fetch_req_t;

endpackage

/* verilog/instr_pkg.sv */
//--------------------------------------------------------------------------
// extracted instruction slots and the pending upper-half state
//--------------------------------------------------------------------------
`include "realign_cfg.svh"

package instr_pkg;

    // one 16-bit parcel of an instruction
    typedef logic [`REALIGN_HALF_WIDTH-1:0] half_t;

    // a full instruction, compressed ones are zero-extended into it
    typedef logic [2*`REALIGN_HALF_WIDTH-1:0] instr_t;

    // one instruction handed to the decode stage
    typedef struct packed {
        logic             valid;
        fetch_pkg::addr_t addr;
        instr_t           instr;
    } instr_slot_t;

    // all slots of one fetch cycle, slot 0 is the oldest instruction
    typedef instr_slot_t [`REALIGN_INSTR_PER_FETCH-1:0] instr_slots_t;

    //----------------------------------------------------------------------
    // pending half state
    //----------------------------------------------------------------------
    // lower half of a 32-bit instruction that crossed the fetch block
    // boundary, completed by the low parcel of the next block
    typedef struct packed {
        logic             pending;
        half_t            half;
        fetch_pkg::addr_t addr;
    } hold_state_t;

endpackage

/* verilog/realign_slot_decoder.sv */
//--------------------------------------------------------------------------
// compressed detection, slot assembly and next pending-half state
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "realign_cfg.svh"

module realign_slot_decoder (
    input  fetch_pkg::fetch_req_t   fetch_i,
    input  instr_pkg::hold_state_t  hold_q_i,
    output instr_pkg::instr_slots_t slots_o,
    output instr_pkg::hold_state_t  hold_d_o
);

    // a compressed parcel moves to the upper 16 bits as zeros
    function automatic instr_pkg::instr_t zero_extend(input instr_pkg::half_t parcel);
        return {{`REALIGN_HALF_WIDTH{1'b0}}, parcel};
    endfunction

    // one flag per parcel of the fetch word
    logic [fetch_pkg::HALVES_PER_FETCH-1:0] parcel_is_compressed;
    instr_pkg::half_t                       low_half;
    instr_pkg::half_t                       high_half;
    fetch_pkg::addr_t                       base_addr;
    fetch_pkg::addr_t                       upper_addr;
    logic                                   half_start;

    //----------------------------------------------------------------------
    // parcel classification
    //----------------------------------------------------------------------
    // a parcel is compressed unless both opcode bits 1:0 are set
    for (genvar i = 0; i < fetch_pkg::HALVES_PER_FETCH; i++) begin : g_parcel
        assign parcel_is_compressed[i] = ~&fetch_i.word.half[i][1:0];
    end

    assign low_half  = fetch_i.word.half[0];
    assign high_half = fetch_i.word.half[1];

    // the block is always word aligned, the upper parcel sits at offset 2
    assign base_addr  = {fetch_i.addr[`REALIGN_VLEN-1:2], 2'b00};
    assign upper_addr = {fetch_i.addr[`REALIGN_VLEN-1:2], 2'b10};

    // a jump into the middle of a block, e.g. a branch target at offset 2
    assign half_start = fetch_i.valid & fetch_i.addr[1];

    //----------------------------------------------------------------------
    // slot assembly
    //----------------------------------------------------------------------
    always_comb begin : assemble
        // by default the upper parcel is the candidate to be held back
        hold_d_o.pending = 1'b0;
        hold_d_o.half    = high_half;
        hold_d_o.addr    = upper_addr;

        // slot 0 starts out as a full aligned instruction
        slots_o[0].valid = fetch_i.valid;
        slots_o[0].addr  = base_addr;
        slots_o[0].instr = fetch_i.word.full;

        // slot 1 can only ever hold the upper parcel
        slots_o[1].valid = 1'b0;
        slots_o[1].addr  = upper_addr;
        slots_o[1].instr = '0;

        if (hold_q_i.pending) begin
            // splice the saved lower half with the new low parcel
            slots_o[0].instr = {low_half, hold_q_i.half};
            slots_o[0].addr  = hold_q_i.addr;
        end else if (parcel_is_compressed[0]) begin
            slots_o[0].instr = zero_extend(low_half);
        end

        // the low parcel was consumed on its own, so the upper one starts
        // a new instruction that either fits or has to wait for the next block
        if (hold_q_i.pending || parcel_is_compressed[0]) begin
            if (parcel_is_compressed[1]) begin
                slots_o[1].valid = fetch_i.valid;
                slots_o[1].instr = zero_extend(high_half);
            end else begin
                hold_d_o.pending = 1'b1;
            end
        end

        //------------------------------------------------------------------
        // half-word start
        //------------------------------------------------------------------
        // the cache hands the target parcel in the low half, it takes over
        // whatever the aligned decoding above produced
        if (half_start) begin
            slots_o[1].valid = 1'b0;
            hold_d_o.half    = low_half;
            if (parcel_is_compressed[0]) begin
                slots_o[0].valid = 1'b1;
                slots_o[0].addr  = fetch_i.addr;
                slots_o[0].instr = zero_extend(low_half);
                hold_d_o.pending = 1'b0;
            end else begin
                // only the lower half is here, nothing can issue yet
                slots_o[0].valid = 1'b0;
                hold_d_o.pending = 1'b1;
            end
        end
    end

endmodule

/* verilog/realign_hold_regs.sv */
//--------------------------------------------------------------------------
// pending upper-half registers with flush
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module realign_hold_regs (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   flush_i,
    input  logic                   fetch_valid_i,
    input  instr_pkg::hold_state_t hold_d_i,
    output instr_pkg::hold_state_t hold_q_o
);

    instr_pkg::hold_state_t hold_q;

    //----------------------------------------------------------------------
    // state update
    //----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            hold_q <= '0;
        end else begin
            // the saved parcel and its address follow every valid fetch
            if (fetch_valid_i) begin
                hold_q.half <= hold_d_i.half;
                hold_q.addr <= hold_d_i.addr;
            end

            // a flush drops the pending half even without a fetch,
            // the next block is then decoded as aligned
            if (flush_i) begin
                hold_q.pending <= 1'b0;
            end else if (fetch_valid_i) begin
                hold_q.pending <= hold_d_i.pending;
            end
        end
    end

    assign hold_q_o = hold_q;

endmodule

/* verilog/instr_realign_top.sv */
//--------------------------------------------------------------------------
// fetch re-aligner top, slot decoder beside its hold registers
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module instr_realign_top (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    input  fetch_pkg::fetch_req_t   fetch_i,
    output instr_pkg::instr_slots_t slots_o,
    output logic                    serving_unaligned_o
);

    // next and current pending-half state around the registers
    instr_pkg::hold_state_t hold_d;
    instr_pkg::hold_state_t hold_q;

    //----------------------------------------------------------------------
    // combinational slot extraction
    //----------------------------------------------------------------------
    // slots leave in the same cycle as the fetch strobe
    realign_slot_decoder u_slot_decoder (
        .fetch_i  (fetch_i),
        .hold_q_i (hold_q),
        .slots_o  (slots_o),
        .hold_d_o (hold_d)
    );

    //----------------------------------------------------------------------
    // pending half storage
    //----------------------------------------------------------------------
    realign_hold_regs u_hold_regs (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_i       (flush_i),
        .fetch_valid_i (fetch_i.valid),
        .hold_d_i      (hold_d),
        .hold_q_o      (hold_q)
    );

    // slot 0 of the next block completes a held instruction
    assign serving_unaligned_o = hold_q.pending;

endmodule

/* testbench/tb_clock_gen.sv */
//--------------------------------------------------------------------------
// testbench clock, 4 ns period, and active-low reset of 8 cycles
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int unsigned HALF_PERIOD_NS = 2,
    parameter int unsigned RESET_CYCLES   = 8
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

    // reset leaves on a rising edge so the flops see it go away cleanly
    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_no <= 1'b1;
    end

endmodule

/* testbench/tb_realign_checker.sv */
//--------------------------------------------------------------------------
// checker comparing re-aligner slots and pending flag with expectations
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "realign_cfg.svh"

module tb_realign_checker (
    input  logic                    clk_i,
    input  logic                    check_en_i,
    input  instr_pkg::instr_slots_t exp_slots_i,
    input  logic                    exp_unaligned_i,
    input  instr_pkg::instr_slots_t slots_i,
    input  logic                    serving_unaligned_i,
    output int unsigned             error_count_o,
    output int unsigned             check_count_o
);

    // expectation for the pending flag, due one edge after its stimulus
    logic unal_due;
    logic unal_exp_q;

    initial begin
        error_count_o = 0;
        check_count_o = 0;
        unal_due      = 1'b0;
        unal_exp_q    = 1'b0;
    end

    // widens one compared value to 32 bits so that every field fits
    task automatic compare_field(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        check_count_o++;
        if (got !== exp) begin
            error_count_o++;
            $display("Error at %t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // instruction and address only matter for a slot that should issue
    task automatic compare_slot(input int idx);
        instr_pkg::instr_slot_t got;
        instr_pkg::instr_slot_t exp;
        got = slots_i[idx];
        exp = exp_slots_i[idx];
        compare_field($sformatf("slot %0d valid", idx), {31'b0, got.valid},
                      {31'b0, exp.valid});
        if (exp.valid) begin
            compare_field($sformatf("slot %0d instr", idx), got.instr, exp.instr);
            compare_field($sformatf("slot %0d addr", idx), got.addr, exp.addr);
        end
    endtask

    //----------------------------------------------------------------------
    // sampling on the falling edge, halfway between driving edges
    //----------------------------------------------------------------------
    always @(negedge clk_i) begin
        // the flag now shows the update made by the previous stimulus
        if (unal_due) begin
            compare_field("serving_unaligned", {31'b0, serving_unaligned_i},
                          {31'b0, unal_exp_q});
        end
        // slots are combinational and belong to the stimulus of this cycle
        if (check_en_i) begin
            for (int i = 0; i < `REALIGN_INSTR_PER_FETCH; i++) begin
                compare_slot(i);
            end
        end
        unal_due   = check_en_i;
        unal_exp_q = exp_unaligned_i;
    end

endmodule

/* testbench/tb_instr_realign.sv */
//--------------------------------------------------------------------------
// testbench top for the fetch re-aligner, stimulus from the data file
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_instr_realign;

    localparam int unsigned RESET_TIMEOUT = 32;
    localparam int unsigned MAX_CYCLES    = 256;
    localparam string       DATA_FILE     = "testbench/realign_testdata.txt";

    logic                    clk;
    logic                    rst_n;
    logic                    flush;
    fetch_pkg::fetch_req_t   fetch;
    instr_pkg::instr_slots_t slots;
    logic                    serving_unaligned;

    // expectations handed to the checker together with the stimulus
    logic                    check_en;
    instr_pkg::instr_slots_t exp_slots;
    logic                    exp_unaligned;
    int unsigned             error_count;
    int unsigned             check_count;

    tb_clock_gen u_clock_gen (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    instr_realign_top u_dut (
        .clk_i               (clk),
        .rst_ni              (rst_n),
        .flush_i             (flush),
        .fetch_i             (fetch),
        .slots_o             (slots),
        .serving_unaligned_o (serving_unaligned)
    );

    tb_realign_checker u_checker (
        .clk_i               (clk),
        .check_en_i          (check_en),
        .exp_slots_i         (exp_slots),
        .exp_unaligned_i     (exp_unaligned),
        .slots_i             (slots),
        .serving_unaligned_i (serving_unaligned),
        .error_count_o       (error_count),
        .check_count_o       (check_count)
    );

    // blank lines and lines starting with # carry no stimulus
    function automatic bit is_data_line(input string line);
        if (line.len() == 0) begin
            return 1'b0;
        end
        return line.getc(0) != "#" && line.getc(0) != "\n";
    endfunction

    //----------------------------------------------------------------------
    // stimulus
    //----------------------------------------------------------------------
    initial begin : stimulus
        int                      fd;
        int                      cycles;
        int                      lines_applied;
        bit                      ok;
        string                   line;
        logic [31:0]             col [10];
        instr_pkg::instr_slots_t exp_next;

        $timeformat(-9, 0, " ns", 0);
        flush         = 1'b0;
        fetch         = '0;
        check_en      = 1'b0;
        exp_slots     = '0;
        exp_unaligned = 1'b0;
        ok            = 1'b1;
        lines_applied = 0;

        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("could not open the stimulus file %s", DATA_FILE);
            ok = 1'b0;
        end

        cycles = 0;
        while (ok && rst_n !== 1'b1) begin
            if (cycles >= RESET_TIMEOUT) begin
                $display("reset was not released within %0d clock cycles", RESET_TIMEOUT);
                ok = 1'b0;
            end else begin
                @(posedge clk);
                cycles++;
            end
        end

        // columns: flush valid addr data slot-valids instr0 addr0 instr1 addr1 unaligned
        cycles = 0;
        while (ok && !$feof(fd)) begin
            if (cycles >= MAX_CYCLES) begin
                $display("stimulus file not finished after %0d clock cycles", MAX_CYCLES);
                ok = 1'b0;
            end else begin
                line = "";
                void'($fgets(line, fd));
                if (is_data_line(line)) begin
                    if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h", col[0], col[1],
                                col[2], col[3], col[4], col[5], col[6], col[7], col[8],
                                col[9]) != 10) begin
                        $display("malformed stimulus line: %s", line);
                        ok = 1'b0;
                    end else begin
                        exp_next          = '0;
                        exp_next[0].valid = col[4][0];
                        exp_next[0].instr = col[5];
                        exp_next[0].addr  = col[6];
                        exp_next[1].valid = col[4][1];
                        exp_next[1].instr = col[7];
                        exp_next[1].addr  = col[8];
                        @(posedge clk);
                        cycles++;
                        flush           <= col[0][0];
                        fetch.valid     <= col[1][0];
                        fetch.addr      <= col[2];
                        fetch.word.full <= col[3];
                        exp_slots       <= exp_next;
                        exp_unaligned   <= col[9][0];
                        check_en        <= 1'b1;
                        lines_applied++;
                    end
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        // idle cycle, then one more edge so the last pending flag is compared
        @(posedge clk);
        flush    <= 1'b0;
        fetch    <= '0;
        check_en <= 1'b0;
        @(posedge clk);
        @(posedge clk);

        if (ok && lines_applied == 0) begin
            $display("the stimulus file held no stimulus lines");
            ok = 1'b0;
        end

        $display("checks: %0d, errors: %0d, stimulus lines: %0d",
                 check_count, error_count, lines_applied);
        if (ok && error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+verilog
verilog/fetch_pkg.sv
verilog/instr_pkg.sv
verilog/realign_slot_decoder.sv
verilog/realign_hold_regs.sv
verilog/instr_realign_top.sv
testbench/tb_clock_gen.sv
testbench/tb_realign_checker.sv
testbench/tb_instr_realign.sv

/* testbench/realign_testdata.txt */
# flush valid addr data slot-valids(bit0 = slot 0) instr0 addr0 instr1 addr1 unaligned-after-edge
# all fields hex, instruction and address of a slot that should not issue are ignored
0 1 00001000 45050001 3 00000001 00001000 00004505 00001002 0
0 1 00001004 00a50593 1 00a50593 00001004 00000000 00000000 0
0 1 00001008 06334501 1 00004501 00001008 00000000 00000000 1
0 1 0000100c 808200b5 3 00b50633 0000100a 00008082 0000100e 0
0 1 00001010 85334585 1 00004585 00001010 00000000 00000000 1
0 1 00001014 009300c5 1 00c58533 00001012 00000000 00000000 1
0 0 00001018 deadbeef 0 00000000 00000000 00000000 00000000 1
0 1 00001018 05050010 3 00100093 00001016 00000505 0000101a 0
0 1 0000101c 06334501 1 00004501 0000101c 00000000 00000000 1
1 0 00000000 00000000 0 00000000 00000000 00000000 00000000 0
0 1 00002000 00a50593 1 00a50593 00002000 00000000 00000000 0
0 1 00002004 06334501 1 00004501 00002004 00000000 00000000 1
1 1 00002008 059300b5 1 00b50633 00002006 00000000 00000000 0
0 1 0000200c 45050001 3 00000001 0000200c 00004505 0000200e 0
0 1 00003002 ffff0593 0 00000000 00000000 00000000 00000000 1
0 1 00003004 808200a5 3 00a50593 00003002 00008082 00003006 0
0 1 0000300a 12344501 1 00004501 0000300a 00000000 00000000 0
0 1 00004000 80820040 3 00000040 00004000 00008082 00004002 0
0 0 00000000 00000000 0 00000000 00000000 00000000 00000000 0
